// ==== mrdma_ig_pkg.sv ====
/* mrdma ingress shared definitions */

`default_nettype none

package mrdma_ig_pkg;

  // ======================================================================
  // address widths
  // ======================================================================

  // full byte address on the dma port
  localparam int unsigned mem_addr_width = 32;
  // one atom is 32 bytes
  localparam int unsigned atom_addr_bits = 5;
  // address in atom units, as programmed
  localparam int unsigned elem_addr_width = mem_addr_width - atom_addr_bits;

  // ======================================================================
  // cube shape
  // ======================================================================

  // width, height and channel register fields
  localparam int unsigned dim_width = 13;
  // channel blocks of 16 need one more bit than blocks of 32
  localparam int unsigned chan_blk_width = dim_width - atom_addr_bits + 1;

  // ======================================================================
  // payloads
  // ======================================================================

  localparam int unsigned req_size_width = 15;
  // size sits above the byte address
  localparam int unsigned dma_req_width = mem_addr_width + req_size_width;
  // size in [12:0], cube end in [13]
  localparam int unsigned cq_pd_width = 14;

  // perf counter
  localparam int unsigned stall_cnt_width = 32;

  // ======================================================================
  // input precision codes
  // ======================================================================

  localparam logic [1:0] prec_int8 = 2'd0;
  localparam logic [1:0] prec_int16 = 2'd1;

endpackage

`default_nettype wire

// ==== mrdma_ig_shape_decode.sv ====
/* mrdma ingress cube shape decode */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig_shape_decode (
  input  wire [1:0]                              reg2dp_in_precision,
  input  wire [mrdma_ig_pkg::dim_width-1:0]      reg2dp_channel,
  input  wire [mrdma_ig_pkg::dim_width-1:0]      reg2dp_width,
  input  wire [mrdma_ig_pkg::dim_width-1:0]      reg2dp_height,
  output logic                                   pack_mode,
  output logic [mrdma_ig_pkg::chan_blk_width-1:0] chan_blocks
);

  // 1x1 cube, all channels go out as one packed request
  assign pack_mode = (reg2dp_width == '0) && (reg2dp_height == '0);

  // ======================================================================
  // channel blocks, counted as last index
  // ======================================================================

  always_comb begin
    chan_blocks = '0;
    case (reg2dp_in_precision)
      mrdma_ig_pkg::prec_int8: begin
        // 32 channels of int8 per atom
        chan_blocks[mrdma_ig_pkg::dim_width-mrdma_ig_pkg::atom_addr_bits-1:0] =
          reg2dp_channel[mrdma_ig_pkg::dim_width-1:mrdma_ig_pkg::atom_addr_bits];
      end
      mrdma_ig_pkg::prec_int16: begin
        // 16 channels of int16 per atom
        chan_blocks =
          reg2dp_channel[mrdma_ig_pkg::dim_width-1:mrdma_ig_pkg::atom_addr_bits-1];
      end
      default: begin
        // wider formats also pack 16 per atom
        chan_blocks =
          reg2dp_channel[mrdma_ig_pkg::dim_width-1:mrdma_ig_pkg::atom_addr_bits-1];
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== mrdma_ig_cube_walk.sv ====
/* mrdma ingress cube walk */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig_cube_walk (
  input  wire                                     nvdla_core_clk,
  input  wire                                     nvdla_core_rstn,
  input  wire                                     op_load,
  input  wire                                     cmd_accept,
  input  wire                                     pack_mode,
  input  wire [mrdma_ig_pkg::chan_blk_width-1:0]  chan_blocks,
  input  wire [mrdma_ig_pkg::dim_width-1:0]       reg2dp_height,
  output logic                                    cmd_active,
  output logic                                    surf_end,
  output logic                                    cube_end
);

  logic [mrdma_ig_pkg::dim_width-1:0]      count_h;
  logic [mrdma_ig_pkg::chan_blk_width-1:0] count_c;
  logic                                    is_last_h;
  logic                                    is_last_c;
  logic                                    cmd_done;

  // ======================================================================
  // end flags
  // ======================================================================

  assign is_last_h = (count_h == reg2dp_height);
  assign is_last_c = (count_c == chan_blocks);

  // pack mode: first request ends everything
  assign surf_end = pack_mode | is_last_h;
  assign cube_end = surf_end & (pack_mode | is_last_c);

  assign cmd_done = cmd_accept & cube_end;

  // ======================================================================
  // operation active
  // ======================================================================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cmd_active <= 1'b0;
    end else if (op_load) begin
      cmd_active <= 1'b1;
    end else if (cmd_done) begin
      cmd_active <= 1'b0;
    end
  end

  // line counter, wraps at surface end
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_h <= '0;
    end else if (op_load) begin
      count_h <= '0;
    end else if (cmd_accept) begin
      if (surf_end) begin
        count_h <= '0;
      end else begin
        count_h <= count_h + 1'b1;
      end
    end
  end

  // channel block counter
  // steps once per surface
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      count_c <= '0;
    end else if (op_load) begin
      count_c <= '0;
    end else if (cmd_accept) begin
      if (cube_end) begin
        count_c <= '0;
      end else if (surf_end) begin
        count_c <= count_c + 1'b1;
      end
    end
  end

  // done only inside a started operation
  a_done_when_active : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !(cmd_done && !cmd_active)
  ) else $error("cube end accepted while no operation active");

endmodule

`default_nettype wire

// ==== mrdma_ig_addr_gen.sv ====
/* mrdma ingress address generation */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig_addr_gen (
  input  wire                                      nvdla_core_clk,
  input  wire                                      nvdla_core_rstn,
  input  wire                                      op_load,
  input  wire                                      cmd_accept,
  input  wire                                      surf_end,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_base_addr_low,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_line_stride,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_surface_stride,
  output logic [mrdma_ig_pkg::mem_addr_width-1:0]  req_addr
);

  logic [mrdma_ig_pkg::elem_addr_width-1:0] base_addr_line;
  logic [mrdma_ig_pkg::elem_addr_width-1:0] base_addr_surf;
  // one extra bit to catch wrap
  logic [mrdma_ig_pkg::elem_addr_width:0]   line_sum;
  logic [mrdma_ig_pkg::elem_addr_width:0]   surf_sum;

  // ======================================================================
  // next base candidates
  // ======================================================================

  assign line_sum = {1'b0, base_addr_line} + {1'b0, reg2dp_src_line_stride};
  assign surf_sum = {1'b0, base_addr_surf} + {1'b0, reg2dp_src_surface_stride};

  // surface base
  always_ff @(posedge nvdla_core_clk) begin
    if (op_load) begin
      base_addr_surf <= reg2dp_src_base_addr_low;
    end else if (cmd_accept && surf_end) begin
      base_addr_surf <= surf_sum[mrdma_ig_pkg::elem_addr_width-1:0];
    end
  end

  // line base
  // next surface restarts from the new surface base
  always_ff @(posedge nvdla_core_clk) begin
    if (op_load) begin
      base_addr_line <= reg2dp_src_base_addr_low;
    end else if (cmd_accept) begin
      if (surf_end) begin
        base_addr_line <= surf_sum[mrdma_ig_pkg::elem_addr_width-1:0];
      end else begin
        base_addr_line <= line_sum[mrdma_ig_pkg::elem_addr_width-1:0];
      end
    end
  end

  // atom to byte address
  assign req_addr = {base_addr_line, {mrdma_ig_pkg::atom_addr_bits{1'b0}}};

  // no wrap of the address space on any step taken
  a_no_addr_wrap : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (cmd_accept && !op_load) |->
      !(surf_end ? surf_sum[mrdma_ig_pkg::elem_addr_width]
                 : line_sum[mrdma_ig_pkg::elem_addr_width])
  ) else $error("address step overflows the atom address range");

endmodule

`default_nettype wire

// ==== mrdma_ig_req_issue.sv ====
/* mrdma ingress request issue */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig_req_issue (
  input  wire                                     nvdla_core_clk,
  input  wire                                     nvdla_core_rstn,
  input  wire                                     cmd_active,
  input  wire                                     pack_mode,
  input  wire [mrdma_ig_pkg::chan_blk_width-1:0]  chan_blocks,
  input  wire [mrdma_ig_pkg::dim_width-1:0]       reg2dp_width,
  input  wire                                     cube_end,
  input  wire [mrdma_ig_pkg::mem_addr_width-1:0]  req_addr,
  input  wire                                     dma_rd_req_rdy,
  input  wire                                     ig2cq_prdy,
  output logic                                    dma_rd_req_vld,
  output logic [mrdma_ig_pkg::dma_req_width-1:0]  dma_rd_req_pd,
  output logic                                    ig2cq_pvld,
  output logic [mrdma_ig_pkg::cq_pd_width-1:0]    ig2cq_pd,
  output logic                                    cmd_accept
);

  logic [mrdma_ig_pkg::req_size_width-1:0] req_size;

  // ======================================================================
  // request size
  // ======================================================================

  always_comb begin
    req_size = '0;
    if (pack_mode) begin
      // one request carries all channel blocks
      req_size[mrdma_ig_pkg::chan_blk_width-1:0] = chan_blocks;
    end else begin
      req_size[mrdma_ig_pkg::dim_width-1:0] = reg2dp_width;
    end
  end

  // cross gated valids
  // neither side sees valid unless the other can take it
  assign dma_rd_req_vld = cmd_active & ig2cq_prdy;
  assign ig2cq_pvld     = cmd_active & dma_rd_req_rdy;
  assign cmd_accept     = dma_rd_req_vld & dma_rd_req_rdy;

  // payloads
  assign dma_rd_req_pd = {req_size, req_addr};
  assign ig2cq_pd      = {cube_end, req_size[mrdma_ig_pkg::cq_pd_width-2:0]};

  // a request held back by either side keeps its payload
  a_payload_hold : assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    (cmd_active && !cmd_accept) |=> ($stable(dma_rd_req_pd) && $stable(ig2cq_pd))
  ) else $error("request payload changed while not accepted");

endmodule

`default_nettype wire

// ==== mrdma_ig_stall_cnt.sv ====
/* mrdma ingress stall counter */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig_stall_cnt (
  input  wire                                      nvdla_core_clk,
  input  wire                                      nvdla_core_rstn,
  input  wire                                      op_load,
  input  wire                                      reg2dp_perf_dma_en,
  input  wire                                      dma_rd_req_vld,
  input  wire                                      dma_rd_req_rdy,
  output logic [mrdma_ig_pkg::stall_cnt_width-1:0] dp2reg_mrdma_stall
);

  logic cnt_en;
  logic stall_inc;

  // valid held against a busy dma
  assign stall_inc = dma_rd_req_vld & ~dma_rd_req_rdy;

  // enable taken per operation
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cnt_en <= 1'b0;
    end else if (op_load) begin
      cnt_en <= reg2dp_perf_dma_en;
    end
  end

  // clear on load only when the old enable was set
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      dp2reg_mrdma_stall <= '0;
    end else if (cnt_en) begin
      if (op_load) begin
        dp2reg_mrdma_stall <= '0;
      end else if (stall_inc) begin
        dp2reg_mrdma_stall <= dp2reg_mrdma_stall + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== mrdma_ig.sv ====
/* mrdma read ingress top */

`timescale 1ns/1ps
`default_nettype none

module mrdma_ig (
  input  wire                                      nvdla_core_clk,
  input  wire                                      nvdla_core_rstn,
  input  wire                                      op_load,
  // configuration, stable during an operation
  input  wire [mrdma_ig_pkg::dim_width-1:0]        reg2dp_channel,
  input  wire [mrdma_ig_pkg::dim_width-1:0]        reg2dp_height,
  input  wire [mrdma_ig_pkg::dim_width-1:0]        reg2dp_width,
  input  wire [1:0]                                reg2dp_in_precision,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_base_addr_low,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_line_stride,
  input  wire [mrdma_ig_pkg::elem_addr_width-1:0]  reg2dp_src_surface_stride,
  input  wire                                      reg2dp_src_ram_type,
  input  wire                                      reg2dp_perf_dma_en,
  // dma read request
  output logic                                     dma_rd_req_vld,
  input  wire                                      dma_rd_req_rdy,
  output logic [mrdma_ig_pkg::dma_req_width-1:0]   dma_rd_req_pd,
  output logic                                     dma_rd_req_ram_type,
  // context queue
  output logic                                     ig2cq_pvld,
  input  wire                                      ig2cq_prdy,
  output logic [mrdma_ig_pkg::cq_pd_width-1:0]     ig2cq_pd,
  // perf
  output logic [mrdma_ig_pkg::stall_cnt_width-1:0] dp2reg_mrdma_stall
);

  logic                                    pack_mode;
  logic [mrdma_ig_pkg::chan_blk_width-1:0] chan_blocks;
  logic                                    cmd_active;
  logic                                    cmd_accept;
  logic                                    surf_end;
  logic                                    cube_end;
  logic [mrdma_ig_pkg::mem_addr_width-1:0] req_addr;

  // ram select passes straight through
  assign dma_rd_req_ram_type = reg2dp_src_ram_type;

  mrdma_ig_shape_decode u_shape_decode (
    .reg2dp_in_precision (reg2dp_in_precision),
    .reg2dp_channel      (reg2dp_channel),
    .reg2dp_width        (reg2dp_width),
    .reg2dp_height       (reg2dp_height),
    .pack_mode           (pack_mode),
    .chan_blocks         (chan_blocks)
  );

  mrdma_ig_cube_walk u_cube_walk (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .op_load         (op_load),
    .cmd_accept      (cmd_accept),
    .pack_mode       (pack_mode),
    .chan_blocks     (chan_blocks),
    .reg2dp_height   (reg2dp_height),
    .cmd_active      (cmd_active),
    .surf_end        (surf_end),
    .cube_end        (cube_end)
  );

  mrdma_ig_addr_gen u_addr_gen (
    .nvdla_core_clk            (nvdla_core_clk),
    .nvdla_core_rstn           (nvdla_core_rstn),
    .op_load                   (op_load),
    .cmd_accept                (cmd_accept),
    .surf_end                  (surf_end),
    .reg2dp_src_base_addr_low  (reg2dp_src_base_addr_low),
    .reg2dp_src_line_stride    (reg2dp_src_line_stride),
    .reg2dp_src_surface_stride (reg2dp_src_surface_stride),
    .req_addr                  (req_addr)
  );

  mrdma_ig_req_issue u_req_issue (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .cmd_active      (cmd_active),
    .pack_mode       (pack_mode),
    .chan_blocks     (chan_blocks),
    .reg2dp_width    (reg2dp_width),
    .cube_end        (cube_end),
    .req_addr        (req_addr),
    .dma_rd_req_rdy  (dma_rd_req_rdy),
    .ig2cq_prdy      (ig2cq_prdy),
    .dma_rd_req_vld  (dma_rd_req_vld),
    .dma_rd_req_pd   (dma_rd_req_pd),
    .ig2cq_pvld      (ig2cq_pvld),
    .ig2cq_pd        (ig2cq_pd),
    .cmd_accept      (cmd_accept)
  );

  mrdma_ig_stall_cnt u_stall_cnt (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .op_load            (op_load),
    .reg2dp_perf_dma_en (reg2dp_perf_dma_en),
    .dma_rd_req_vld     (dma_rd_req_vld),
    .dma_rd_req_rdy     (dma_rd_req_rdy),
    .dp2reg_mrdma_stall (dp2reg_mrdma_stall)
  );

endmodule

`default_nettype wire

// ==== tb_mrdma_ig.sv ====
/* mrdma ingress directed testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_mrdma_ig;

  localparam int unsigned aw = mrdma_ig_pkg::mem_addr_width;
  localparam int unsigned ew = mrdma_ig_pkg::elem_addr_width;
  localparam int unsigned dw = mrdma_ig_pkg::dim_width;
  localparam int unsigned sw = mrdma_ig_pkg::req_size_width;

  // DUT inputs
  logic          nvdla_core_clk = 1'b0;
  logic          nvdla_core_rstn = 1'b0;
  logic          op_load;
  logic [dw-1:0] reg2dp_channel;
  logic [dw-1:0] reg2dp_height;
  logic [dw-1:0] reg2dp_width;
  logic [1:0]    reg2dp_in_precision;
  logic [ew-1:0] reg2dp_src_base_addr_low;
  logic [ew-1:0] reg2dp_src_line_stride;
  logic [ew-1:0] reg2dp_src_surface_stride;
  logic          reg2dp_src_ram_type;
  logic          reg2dp_perf_dma_en;
  logic          dma_rd_req_rdy;
  logic          ig2cq_prdy;
  // DUT outputs
  logic                                      dma_rd_req_vld;
  logic [mrdma_ig_pkg::dma_req_width-1:0]    dma_rd_req_pd;
  logic                                      dma_rd_req_ram_type;
  logic                                      ig2cq_pvld;
  logic [mrdma_ig_pkg::cq_pd_width-1:0]      ig2cq_pd;
  logic [mrdma_ig_pkg::stall_cnt_width-1:0]  dp2reg_mrdma_stall;

  // expected request list, one entry per accept
  logic [aw-1:0] exp_addr_q[$];
  logic [sw-1:0] exp_size_q[$];
  logic          exp_end_q[$];

  // model state, advanced by the monitor at the falling edge
  logic          active_exp = 1'b0;
  logic          en_exp = 1'b0;
  logic [31:0]   stall_exp = '0;
  logic          exp_dma_vld;
  logic          exp_cq_vld;
  logic          mon_end;
  int            accepts_seen = 0;
  int            ops_started = 0;
  int            ops_done = 0;
  int            last_op_reqs = 0;
  int            total_reqs = 0;
  int            err_cnt = 0;
  int            wd_cycles = 0;
  logic          rand_ready = 1'b0;
  logic [31:0]   rnd;
  integer        seed;

  mrdma_ig dut (.*);

  initial begin
    forever begin
      #4 nvdla_core_clk = ~nvdla_core_clk;
    end
  end

  // ======================================================================
  // checking helpers
  // ======================================================================

  task automatic fail_run(input string why);
    err_cnt++;
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at time %0t: %s got 0x%0h, expected 0x%0h",
                         $time, name, got, exp));
    end
  endtask

  // reference request order: lines inside a surface, surfaces across blocks
  task automatic build_model(input logic [1:0] prec, input logic [dw-1:0] chan,
                             input logic [dw-1:0] w, input logic [dw-1:0] h,
                             input logic [ew-1:0] base, input logic [ew-1:0] ls,
                             input logic [ew-1:0] ss);
    int          s_last;
    int          c;
    int          r;
    logic [31:0] atom;
    s_last = (prec == mrdma_ig_pkg::prec_int8) ? chan[12:5] : chan[12:4];
    if (w == 0 && h == 0) begin
      // 1x1 cube, one packed request
      exp_addr_q.push_back({base, 5'b0});
      exp_size_q.push_back(s_last);
      exp_end_q.push_back(1'b1);
    end else begin
      for (c = 0; c <= s_last; c++) begin
        for (r = 0; r <= h; r++) begin
          atom = base + c * ss + r * ls;
          exp_addr_q.push_back(atom << mrdma_ig_pkg::atom_addr_bits);
          exp_size_q.push_back(w);
          exp_end_q.push_back((c == s_last) && (r == h));
        end
      end
    end
  endtask

  // load one operation and wait for its cube end
  task automatic run_op(input logic [1:0] prec, input logic [dw-1:0] chan,
                        input logic [dw-1:0] w, input logic [dw-1:0] h,
                        input logic [ew-1:0] base, input logic [ew-1:0] ls,
                        input logic [ew-1:0] ss, input logic perf_en, input logic rand_bp);
    int start_accepts;
    int op_reqs;
    build_model(prec, chan, w, h, base, ls, ss);
    op_reqs = exp_addr_q.size();
    total_reqs += op_reqs;
    start_accepts = accepts_seen;
    @(posedge nvdla_core_clk);
    rand_ready <= rand_bp;
    reg2dp_in_precision <= prec;
    reg2dp_channel <= chan;
    reg2dp_width <= w;
    reg2dp_height <= h;
    reg2dp_src_base_addr_low <= base;
    reg2dp_src_line_stride <= ls;
    reg2dp_src_surface_stride <= ss;
    reg2dp_perf_dma_en <= perf_en;
    op_load <= 1'b1;
    @(posedge nvdla_core_clk);
    op_load <= 1'b0;
    ops_started++;
    while (ops_done != ops_started) begin
      @(posedge nvdla_core_clk);
    end
    rand_ready <= 1'b0;
    last_op_reqs = accepts_seen - start_accepts;
    check_value("accepted requests", last_op_reqs, op_reqs);
    check_value("pending requests", exp_addr_q.size(), 0);
  endtask

  // ======================================================================
  // ready drivers and watchdog
  // ======================================================================

  always @(posedge nvdla_core_clk) begin
    if (rand_ready) begin
      rnd = $random(seed);
      // ready about three cycles in four
      dma_rd_req_rdy <= rnd[0] | rnd[1];
      ig2cq_prdy <= rnd[2] | rnd[3];
    end else begin
      dma_rd_req_rdy <= 1'b1;
      ig2cq_prdy <= 1'b1;
    end
  end

  // limit grows with every request loaded
  always @(posedge nvdla_core_clk) begin
    wd_cycles++;
    if (wd_cycles > total_reqs * 40 + 500) begin
      fail_run("watchdog timeout, the DUT stopped issuing requests");
    end
  end

  // ======================================================================
  // monitor, samples where all inputs and outputs are settled
  // ======================================================================

  always @(negedge nvdla_core_clk) begin
    // each valid follows the other side's ready
    exp_dma_vld = active_exp & ig2cq_prdy;
    exp_cq_vld = active_exp & dma_rd_req_rdy;
    check_value("dma_rd_req_vld", dma_rd_req_vld, exp_dma_vld);
    check_value("ig2cq_pvld", ig2cq_pvld, exp_cq_vld);
    // counter lags the stall by one cycle
    check_value("dp2reg_mrdma_stall", dp2reg_mrdma_stall, stall_exp);
    if (en_exp) begin
      if (op_load) begin
        stall_exp = '0;
      end else if (exp_dma_vld && !dma_rd_req_rdy) begin
        stall_exp = stall_exp + 1;
      end
    end
    if (op_load) begin
      en_exp = reg2dp_perf_dma_en;
    end
    mon_end = 1'b0;
    if (exp_dma_vld && dma_rd_req_rdy) begin
      if (exp_addr_q.size() == 0) begin
        fail_run("a request was accepted when none was expected");
      end
      check_value("dma_rd_req_pd.addr", dma_rd_req_pd[aw-1:0], exp_addr_q[0]);
      check_value("dma_rd_req_pd.size", dma_rd_req_pd[aw+sw-1:aw], exp_size_q[0]);
      check_value("ig2cq_pd", ig2cq_pd, {exp_end_q[0], exp_size_q[0][12:0]});
      mon_end = exp_end_q[0];
      void'(exp_addr_q.pop_front());
      void'(exp_size_q.pop_front());
      void'(exp_end_q.pop_front());
      accepts_seen++;
      // the DUT's own cube end bit closes the operation
      if (ig2cq_pd[mrdma_ig_pkg::cq_pd_width-1]) begin
        ops_done++;
      end
    end
    if (op_load) begin
      active_exp = 1'b1;
    end else if (mon_end) begin
      active_exp = 1'b0;
    end
  end

  // ======================================================================
  // directed tests
  // ======================================================================

  task automatic test_reset_state();
    @(posedge nvdla_core_clk);
    reg2dp_src_ram_type <= 1'b1;
    @(posedge nvdla_core_clk);
    check_value("dma_rd_req_vld", dma_rd_req_vld, 0);
    check_value("ig2cq_pvld", ig2cq_pvld, 0);
    check_value("dp2reg_mrdma_stall", dp2reg_mrdma_stall, 0);
    check_value("dma_rd_req_ram_type", dma_rd_req_ram_type, 1);
  endtask

  task automatic test_int8_cube();
    // 64 channels of int8, last block index 2
    run_op(mrdma_ig_pkg::prec_int8, 13'd64, 13'd15, 13'd3, 'h100, 'h10, 'h80, 1'b0, 1'b0);
    check_value("int8 request count", last_op_reqs, 3 * 4);
  endtask

  task automatic test_int16_cube();
    // same channel field, last block index doubles to 4
    run_op(mrdma_ig_pkg::prec_int16, 13'd64, 13'd15, 13'd3, 'h2000, 'h8, 'h40, 1'b0, 1'b0);
    check_value("int16 request count", last_op_reqs, 5 * 4);
  endtask

  task automatic test_pack_mode();
    run_op(mrdma_ig_pkg::prec_int8, 13'd100, 13'd0, 13'd0, 'h345, 'h10, 'h80, 1'b0, 1'b0);
    check_value("pack request count", last_op_reqs, 1);
    // precision code 2 packs 16 channels per block
    run_op(2'd2, 13'd100, 13'd0, 13'd0, 'h1234, 'h10, 'h80, 1'b0, 1'b0);
    check_value("pack request count", last_op_reqs, 1);
  endtask

  task automatic test_backpressure();
    run_op(mrdma_ig_pkg::prec_int8, 13'd96, 13'd7, 13'd4, 'h40, 'h20, 'h200, 1'b0, 1'b1);
  endtask

  task automatic test_stall_count();
    run_op(mrdma_ig_pkg::prec_int16, 13'd48, 13'd3, 13'd5, 'h800, 'h4, 'h30, 1'b1, 1'b1);
    if (stall_exp == 0) begin
      fail_run("no dma stall cycle was seen while counting was enabled");
    end
    repeat (2) @(posedge nvdla_core_clk);
    check_value("dp2reg_mrdma_stall", dp2reg_mrdma_stall, stall_exp);
    // counting off, old enable clears the count
    run_op(mrdma_ig_pkg::prec_int16, 13'd48, 13'd3, 13'd5, 'h800, 'h4, 'h30, 1'b0, 1'b1);
    repeat (2) @(posedge nvdla_core_clk);
    check_value("dp2reg_mrdma_stall", dp2reg_mrdma_stall, 0);
  endtask

  initial begin
    seed = 30;
    op_load = 1'b0;
    reg2dp_channel = '0;
    reg2dp_height = '0;
    reg2dp_width = '0;
    reg2dp_in_precision = mrdma_ig_pkg::prec_int8;
    reg2dp_src_base_addr_low = '0;
    reg2dp_src_line_stride = '0;
    reg2dp_src_surface_stride = '0;
    reg2dp_src_ram_type = 1'b0;
    reg2dp_perf_dma_en = 1'b0;
    dma_rd_req_rdy = 1'b1;
    ig2cq_prdy = 1'b1;
    repeat (10) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;
    test_reset_state();
    test_int8_cube();
    test_int16_cube();
    test_pack_mode();
    test_backpressure();
    test_stall_count();
    repeat (4) @(posedge nvdla_core_clk);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mrdma_ig.f ====
mrdma_ig_pkg.sv
mrdma_ig_shape_decode.sv
mrdma_ig_cube_walk.sv
mrdma_ig_addr_gen.sv
mrdma_ig_req_issue.sv
mrdma_ig_stall_cnt.sv
mrdma_ig.sv
tb_mrdma_ig.sv

// ==== Bender.yml ====
package:
  name: mrdma_ig

sources:
  - mrdma_ig_pkg.sv
  - mrdma_ig_shape_decode.sv
  - mrdma_ig_cube_walk.sv
  - mrdma_ig_addr_gen.sv
  - mrdma_ig_req_issue.sv
  - mrdma_ig_stall_cnt.sv
  - mrdma_ig.sv
  - target: test
    files:
      - tb_mrdma_ig.sv
